/* flist.f */
hdl/isa_pkg.sv
hdl/pipe_pkg.sv
hdl/operand_resolve.sv
hdl/interlock_detect.sv
hdl/issue_register.sv
hdl/issue_stage.sv
verif/tb_issue_stage.sv

/* verif/tb_issue_stage.sv */
`timescale 1ns/1ns

module tb_issue_stage;

        import isa_pkg::*;
        import pipe_pkg::*;

        localparam int CLK_PERIOD      = 20;
        localparam int DRIVE_DELAY     = 2;
        localparam int NUM_TESTS       = 6;
        localparam int CYCLES_PER_TEST = 20;
        localparam int WATCHDOG_NS     = 2 * NUM_TESTS * CYCLES_PER_TEST * CLK_PERIOD;

        logic           clk;
        logic           reset;
        logic           data_stall;
        logic           clear_from_alu;
        decoded_t       decoded;
        forward_t       fwd;
        reg_data_t      rd_data;
        reg_index_t     rd_index;
        issued_t        issued;
        logic           stall_from_issue;

        integer         seed;
        int             checks;
        int             errors;

        issue_stage i_dut
        (
                .i_clk                  (clk),
                .i_reset                (reset),
                .i_data_stall           (data_stall),
                .i_clear_from_alu       (clear_from_alu),
                .i_decoded              (decoded),
                .i_fwd                  (fwd),
                .i_rd_data              (rd_data),
                .o_rd_index             (rd_index),
                .o_issued               (issued),
                .o_stall_from_issue     (stall_from_issue)
        );

        initial
        begin
                clk = 1'b0;
                forever
                begin
                        #(CLK_PERIOD / 2) clk = ~clk;
                end
        end

        initial
        begin
                #(WATCHDOG_NS);
                $display("Watchdog expired before the tests completed");
                $display("Something failed");
                $finish;
        end

        function automatic operand_t imm_operand(input logic [31:0] value);
                operand_t op;
                op.immed = IMMED_EN;
                op.value = value;
                return op;
        endfunction

        function automatic operand_t reg_operand(input logic [IDX_W-1:0] idx);
                operand_t op;
                op.immed = ~IMMED_EN;
                op.value = '0;
                op.value[IDX_W-1:0] = idx;
                return op;
        endfunction

        // Plain data processing instruction, condition AL, no memory access.
        function automatic decoded_t build_instr(input logic [IDX_W-1:0] dest,
                                                 input shift_op_t sop,
                                                 input operand_t alu_src,
                                                 input operand_t shift_src,
                                                 input operand_t shift_len,
                                                 input logic [IDX_W-1:0] store_idx,
                                                 input logic [31:0] pc);
                decoded_t d;
                d                   = '0;
                d.cond              = AL;
                d.dest_index        = dest;
                d.alu_op            = 5'd4;
                d.shift_op          = sop;
                d.alu_source        = alu_src;
                d.shift_source      = shift_src;
                d.shift_length      = shift_len;
                d.mem_srcdest_index = store_idx;
                d.pc_plus_8         = pc;
                return d;
        endfunction

        task automatic load_random_rd_data();
                rd_data.alu_source   = $random(seed);
                rd_data.shift_source = $random(seed);
                rd_data.shift_length = $random(seed);
                rd_data.mem_srcdest  = $random(seed);
        endtask

        // Inputs change here, registered outputs are settled.
        task automatic next_drive_point();
                @(posedge clk);
                #(DRIVE_DELAY);
        endtask

        task automatic wait_mid_cycle();
                #(CLK_PERIOD / 2 - DRIVE_DELAY);
        endtask

        task automatic check_value(input string test_name, input string what,
                                   input logic [31:0] expected, input logic [31:0] actual);
                checks++;
                assert (actual === expected)
                else
                begin
                        $display("[FAIL] %s: %s expected %h, actual %h",
                                 test_name, what, expected, actual);
                        errors++;
                end
        endtask

        task automatic check_bubble(input string test_name);
                issued_t expected;
                expected           = '0;
                expected.instr.cond = NV;
                checks++;
                assert (issued === expected)
                else
                begin
                        $display("[FAIL] %s: bubble expected %h, actual %h",
                                 test_name, expected, issued);
                        errors++;
                end
        endtask

        task automatic test_pass_through();
                decoded_t instr;
                instr = build_instr(6'd3, ROR, imm_operand(32'h1234_5678),
                                    imm_operand(32'hcafe_0001), imm_operand(32'd7),
                                    6'd9, 32'h0000_0108);
                decoded = instr;
                fwd     = '0;
                load_random_rd_data();
                wait_mid_cycle();
                check_value("pass_through", "rd_index alu", 32'(6'h38), 32'(rd_index.alu_source));
                check_value("pass_through", "rd_index shift", 32'(6'h01),
                            32'(rd_index.shift_source));
                check_value("pass_through", "rd_index length", 32'(6'h07),
                            32'(rd_index.shift_length));
                check_value("pass_through", "rd_index store", 32'(6'd9),
                            32'(rd_index.mem_srcdest));
                check_value("pass_through", "stall", 32'(0), 32'(stall_from_issue));
                next_drive_point();
                check_value("pass_through", "cond", 32'(AL), 32'(issued.instr.cond));
                check_value("pass_through", "pc", 32'h0000_0108, issued.instr.pc_plus_8);
                check_value("pass_through", "alu value", 32'h1234_5678, issued.values.alu_source);
                check_value("pass_through", "shift value", 32'hcafe_0001,
                            issued.values.shift_source);
                check_value("pass_through", "length value", 32'd7, issued.values.shift_length);
                check_value("pass_through", "store value", rd_data.mem_srcdest,
                            issued.values.mem_srcdest);
        endtask

        task automatic test_forward_priority();
                logic [31:0] v_nxt;
                logic [31:0] v_ff;
                logic [31:0] v_mem;
                v_nxt   = $random(seed);
                v_ff    = $random(seed);
                v_mem   = $random(seed);
                decoded = build_instr(6'd20, ROR, reg_operand(6'd12), imm_operand(32'h11),
                                      imm_operand(32'd3), 6'd30, 32'h0000_0208);
                fwd                    = '0;
                fwd.shifter_dest_index = 6'd12;
                fwd.alu_dav_nxt        = 1'b1;
                fwd.alu_value_nxt      = v_nxt;
                fwd.alu_dest_index_ff  = 6'd12;
                fwd.alu_dav_ff         = 1'b1;
                fwd.alu_value_ff       = v_ff;
                fwd.mem_dest_index     = 6'd12;
                fwd.mem_dav            = 1'b1;
                fwd.mem_value          = v_mem;
                load_random_rd_data();
                next_drive_point();
                check_value("forward_priority", "alu next", v_nxt, issued.values.alu_source);
                // Drop the youngest producer each step.
                fwd.alu_dav_nxt = 1'b0;
                load_random_rd_data();
                next_drive_point();
                check_value("forward_priority", "alu reg", v_ff, issued.values.alu_source);
                fwd.alu_dav_ff = 1'b0;
                load_random_rd_data();
                next_drive_point();
                check_value("forward_priority", "memory", v_mem, issued.values.alu_source);
                fwd.mem_dav = 1'b0;
                load_random_rd_data();
                next_drive_point();
                check_value("forward_priority", "reg file", rd_data.alu_source,
                            issued.values.alu_source);
        endtask

        task automatic test_load_accelerator();
                logic [31:0] load_data;
                load_data = $random(seed);
                decoded   = build_instr(6'd25, ROR, reg_operand(6'd17), imm_operand(32'h22),
                                        imm_operand(32'd1), 6'd17, 32'h0000_0308);
                fwd                          = '0;
                fwd.alu_dest_index_ff        = 6'd17;
                fwd.alu_dav_ff               = 1'b1;
                fwd.alu_value_ff             = $random(seed);
                fwd.mem_dest_index           = 6'd17;
                fwd.mem_dav                  = 1'b1;
                fwd.mem_value                = $random(seed);
                fwd.memory_mem_srcdest_index = 6'd17;
                fwd.memory_mem_load          = 1'b1;
                fwd.mem_load_data            = load_data;
                load_random_rd_data();
                next_drive_point();
                check_value("load_accelerator", "alu value", load_data, issued.values.alu_source);
                check_value("load_accelerator", "store value", load_data,
                            issued.values.mem_srcdest);
                fwd = '0;
        endtask

        task automatic test_shift_lock();
                decoded = build_instr(6'd5, ROR, imm_operand(32'h5), imm_operand(32'h6),
                                      imm_operand(32'd2), 6'd0, 32'h0000_0408);
                next_drive_point();
                check_value("shift_lock", "writer dest", 32'(6'd5), 32'(issued.instr.dest_index));
                decoded = build_instr(6'd7, LSR, imm_operand(32'h9), reg_operand(6'd5),
                                      imm_operand(32'd2), 6'd0, 32'h0000_0410);
                wait_mid_cycle();
                check_value("shift_lock", "stall", 32'(1), 32'(stall_from_issue));
                next_drive_point();
                check_bubble("shift_lock");
                // Slot is empty now, so the held LSR goes through.
                next_drive_point();
                check_value("shift_lock", "lsr pc", 32'h0000_0410, issued.instr.pc_plus_8);
                decoded = build_instr(6'd5, ROR, imm_operand(32'h5), imm_operand(32'h6),
                                      imm_operand(32'd2), 6'd0, 32'h0000_0418);
                next_drive_point();
                decoded = build_instr(6'd8, LSL, imm_operand(32'h9), reg_operand(6'd5),
                                      imm_operand(32'd0), 6'd0, 32'h0000_0420);
                wait_mid_cycle();
                check_value("shift_bypass", "stall", 32'(0), 32'(stall_from_issue));
                next_drive_point();
                check_value("shift_bypass", "pc", 32'h0000_0420, issued.instr.pc_plus_8);
                check_value("shift_bypass", "shifter disable", 32'(1),
                            32'(issued.shifter_disable));
        endtask

        task automatic test_load_lock();
                decoded = build_instr(6'd11, ROR, reg_operand(6'd22), imm_operand(32'h3),
                                      imm_operand(32'd4), 6'd0, 32'h0000_0508);
                fwd                           = '0;
                fwd.shifter_mem_srcdest_index = 6'd22;
                fwd.shifter_mem_load          = 1'b1;
                fwd.alu_dav_nxt               = 1'b1;
                wait_mid_cycle();
                check_value("load_lock", "stall", 32'(1), 32'(stall_from_issue));
                next_drive_point();
                check_bubble("load_lock");
                fwd = '0;
                load_random_rd_data();
                wait_mid_cycle();
                check_value("load_lock", "stall released", 32'(0), 32'(stall_from_issue));
                next_drive_point();
                check_value("load_lock", "pc", 32'h0000_0508, issued.instr.pc_plus_8);
                check_value("load_lock", "alu value", rd_data.alu_source, issued.values.alu_source);
        endtask

        task automatic test_stall_clear();
                decoded = build_instr(6'd2, ROR, imm_operand(32'h60), imm_operand(32'h61),
                                      imm_operand(32'd5), 6'd0, 32'h0000_0608);
                next_drive_point();
                data_stall = 1'b1;
                decoded    = build_instr(6'd4, ROR, imm_operand(32'h70), imm_operand(32'h71),
                                         imm_operand(32'd6), 6'd0, 32'h0000_0708);
                next_drive_point();
                check_value("stall_clear", "held pc", 32'h0000_0608, issued.instr.pc_plus_8);
                next_drive_point();
                check_value("stall_clear", "held pc again", 32'h0000_0608,
                            issued.instr.pc_plus_8);
                data_stall     = 1'b0;
                clear_from_alu = 1'b1;
                next_drive_point();
                check_bubble("stall_clear");
                clear_from_alu = 1'b0;
                next_drive_point();
                check_value("stall_clear", "new pc", 32'h0000_0708, issued.instr.pc_plus_8);
                reset = 1'b1;
                next_drive_point();
                reset = 1'b0;
                check_bubble("reset");
                wait_mid_cycle();
                check_value("reset", "stall", 32'(0), 32'(stall_from_issue));
        endtask

        initial
        begin
                seed           = 16;
                checks         = 0;
                errors         = 0;
                reset          = 1'b1;
                data_stall     = 1'b0;
                clear_from_alu = 1'b0;
                decoded        = '0;
                decoded.cond   = NV;
                fwd            = '0;
                rd_data        = '0;
                repeat (5)
                begin
                        @(posedge clk);
                end
                #(DRIVE_DELAY);
                reset = 1'b0;
                check_bubble("after_reset");

                test_pass_through();
                test_forward_priority();
                test_load_accelerator();
                test_shift_lock();
                test_load_lock();
                test_stall_clear();

                $display("Checks run: %0d, errors: %0d", checks, errors);
                if (errors == 0)
                begin
                        $display("Everything OK");
                end
                else
                begin
                        $display("Something failed");
                end
                $finish;
        end

endmodule

/* hdl/issue_stage.sv */
`timescale 1ns/1ns

module issue_stage
(
        input  logic                    i_clk,
        input  logic                    i_reset,
        input  logic                    i_data_stall,
        input  logic                    i_clear_from_alu,
        input  pipe_pkg::decoded_t      i_decoded,
        input  pipe_pkg::forward_t      i_fwd,
        input  pipe_pkg::reg_data_t     i_rd_data,
        output pipe_pkg::reg_index_t    o_rd_index,
        output pipe_pkg::issued_t       o_issued,
        output logic                    o_stall_from_issue
);

        import isa_pkg::*;
        import pipe_pkg::*;

        reg_data_t      values;
        operand_t       store_operand;
        logic           lock;
        logic           shifter_disable;

        // Store data is always a register.
        assign store_operand = '{immed: ~IMMED_EN, value: 32'(i_decoded.mem_srcdest_index)};

        // Read ports are addressed straight from decode.
        assign o_rd_index = '{
                alu_source:   i_decoded.alu_source.value[IDX_W-1:0],
                shift_source: i_decoded.shift_source.value[IDX_W-1:0],
                shift_length: i_decoded.shift_length.value[IDX_W-1:0],
                mem_srcdest:  i_decoded.mem_srcdest_index
        };

        operand_resolve u_alu_source
        (
                .i_operand      (i_decoded.alu_source),
                .i_rd_data      (i_rd_data.alu_source),
                .i_fwd          (i_fwd),
                .o_value        (values.alu_source)
        );

        operand_resolve u_shift_source
        (
                .i_operand      (i_decoded.shift_source),
                .i_rd_data      (i_rd_data.shift_source),
                .i_fwd          (i_fwd),
                .o_value        (values.shift_source)
        );

        operand_resolve u_shift_length
        (
                .i_operand      (i_decoded.shift_length),
                .i_rd_data      (i_rd_data.shift_length),
                .i_fwd          (i_fwd),
                .o_value        (values.shift_length)
        );

        operand_resolve u_store_data
        (
                .i_operand      (store_operand),
                .i_rd_data      (i_rd_data.mem_srcdest),
                .i_fwd          (i_fwd),
                .o_value        (values.mem_srcdest)
        );

        interlock_detect u_interlock
        (
                .i_decoded              (i_decoded),
                .i_issued               (o_issued),
                .i_fwd                  (i_fwd),
                .o_lock                 (lock),
                .o_shifter_disable      (shifter_disable)
        );

        issue_register u_issue_reg
        (
                .i_clk                  (i_clk),
                .i_reset                (i_reset),
                .i_data_stall           (i_data_stall),
                .i_clear_from_alu       (i_clear_from_alu),
                .i_lock                 (lock),
                .i_decoded              (i_decoded),
                .i_values               (values),
                .i_shifter_disable      (shifter_disable),
                .o_issued               (o_issued)
        );

        // Decode holds while the lock stands.
        assign o_stall_from_issue = lock;

endmodule

/* hdl/issue_register.sv */
`timescale 1ns/1ns

module issue_register
(
        input  logic                    i_clk,
        input  logic                    i_reset,
        input  logic                    i_data_stall,
        input  logic                    i_clear_from_alu,
        input  logic                    i_lock,
        input  pipe_pkg::decoded_t      i_decoded,
        input  pipe_pkg::reg_data_t     i_values,
        input  logic                    i_shifter_disable,
        output pipe_pkg::issued_t       o_issued
);

        import isa_pkg::*;
        import pipe_pkg::*;

        issued_t        bubble;
        issued_t        issued_nxt;

        // Empty slot: condition NV, all else zero.
        always_comb
        begin
                bubble            = '0;
                bubble.instr.cond = NV;
        end

        always_comb
        begin
                issued_nxt.instr           = i_decoded;
                issued_nxt.values          = i_values;
                issued_nxt.shifter_disable = i_shifter_disable;
        end

        always_ff @(posedge i_clk)
        begin
                if (i_reset)
                begin
                        o_issued <= bubble;
                end
                else if (i_data_stall)
                begin
                        // Later stages are frozen.
                        o_issued <= o_issued;
                end
                else if (i_clear_from_alu)
                begin
                        // Flush after a taken branch in the ALU.
                        o_issued <= bubble;
                end
                else if (i_lock)
                begin
                        // Decode holds, so the slot goes empty.
                        o_issued <= bubble;
                end
                else
                begin
                        o_issued <= issued_nxt;
                end
        end

        // An empty slot must never reach memory.
        a_bubble_no_mem: assert property (@(posedge i_clk) disable iff (i_reset)
                (o_issued.instr.cond == NV)
                |-> !(o_issued.instr.mem_load || o_issued.instr.mem_store))
        else $error("Bubble carries a load or store");

        a_stall_holds: assert property (@(posedge i_clk) disable iff (i_reset)
                i_data_stall |=> $stable(o_issued))
        else $error("Issue register changed under data stall");

endmodule

/* hdl/interlock_detect.sv */
`timescale 1ns/1ns

module interlock_detect
(
        input  pipe_pkg::decoded_t      i_decoded,
        input  pipe_pkg::issued_t       i_issued,
        input  pipe_pkg::forward_t      i_fwd,
        output logic                    o_lock,
        output logic                    o_shifter_disable
);

        import isa_pkg::*;

        logic   bypass;
        logic   issued_valid;
        logic   shift_lock;
        logic   load_lock;

        // True when a register operand names the given index.
        function automatic logic reg_match(input operand_t op, input logic [IDX_W-1:0] idx);
                logic hit;
                hit = (op.immed != IMMED_EN) && (op.value[IDX_W-1:0] == idx);
                return hit;
        endfunction

        // True when the operand waits on a load in issue, shifter or ALU.
        function automatic logic load_wait(input operand_t op,
                                           input pipe_pkg::issued_t issued,
                                           input pipe_pkg::forward_t fwd);
                logic in_issue;
                logic in_shifter;
                logic in_alu;
                in_issue   = reg_match(op, issued.instr.mem_srcdest_index)
                             && (issued.instr.cond != NV)
                             && issued.instr.mem_load;
                in_shifter = reg_match(op, fwd.shifter_mem_srcdest_index)
                             && fwd.alu_dav_nxt
                             && fwd.shifter_mem_load;
                in_alu     = reg_match(op, fwd.alu_mem_srcdest_index)
                             && fwd.alu_dav_ff
                             && fwd.alu_mem_load;
                return in_issue || in_shifter || in_alu;
        endfunction

        assign issued_valid = (i_issued.instr.cond != NV);

        // LSL #0 leaves the operand untouched.
        assign bypass = (i_decoded.shift_op == LSL)
                        && (i_decoded.shift_length.immed == IMMED_EN)
                        && (i_decoded.shift_length.value == 32'd0);

        assign o_shifter_disable = bypass;

        // The shifter cannot take a result still sitting in the issue flops.
        // RORI operands are immediates, so it never needs that path.
        always_comb
        begin
                shift_lock = 1'b0;
                if (!bypass && (i_decoded.shift_op != RORI) && issued_valid)
                begin
                        shift_lock = reg_match(i_decoded.shift_source, i_issued.instr.dest_index)
                                  || reg_match(i_decoded.shift_length, i_issued.instr.dest_index)
                                  || reg_match(i_decoded.alu_source, i_issued.instr.dest_index);
                end
        end

        assign load_lock = load_wait(i_decoded.alu_source, i_issued, i_fwd)
                           || load_wait(i_decoded.shift_source, i_issued, i_fwd)
                           || load_wait(i_decoded.shift_length, i_issued, i_fwd);

        assign o_lock = shift_lock | load_lock;

        // An empty issue slot with no load in flight leaves nothing to wait for.
        always_comb
        begin
                if (!$isunknown({i_decoded, i_issued, i_fwd}))
                begin
                        a_no_idle_lock: assert final (!(o_lock
                                && (i_issued.instr.cond == NV)
                                && !(i_fwd.alu_dav_nxt && i_fwd.shifter_mem_load)
                                && !(i_fwd.alu_dav_ff && i_fwd.alu_mem_load)))
                        else $error("Lock raised with idle issue slot and no load");
                end
        end

endmodule

/* hdl/operand_resolve.sv */
`timescale 1ns/1ns

module operand_resolve
(
        input  isa_pkg::operand_t       i_operand,
        input  logic [31:0]             i_rd_data,
        input  pipe_pkg::forward_t      i_fwd,
        output logic [31:0]             o_value
);

        import isa_pkg::*;

        logic [IDX_W-1:0]       index;
        logic                   is_reg;
        logic                   hit_alu_nxt;
        logic                   hit_alu_ff;
        logic                   hit_mem;
        logic                   hit_load;

        assign index  = i_operand.value[IDX_W-1:0];
        assign is_reg = (i_operand.immed != IMMED_EN);

        // The shifter destination pairs with the ALU next value.
        // The ALU may still kill the instruction, so its valid is taken.
        assign hit_alu_nxt = (index == i_fwd.shifter_dest_index) && i_fwd.alu_dav_nxt;
        assign hit_alu_ff  = (index == i_fwd.alu_dest_index_ff) && i_fwd.alu_dav_ff;
        assign hit_mem     = (index == i_fwd.mem_dest_index) && i_fwd.mem_dav;

        // Load returning this register in the memory stage.
        assign hit_load = is_reg
                          && (index == i_fwd.memory_mem_srcdest_index)
                          && i_fwd.memory_mem_load
                          && i_fwd.mem_dav;

        always_comb
        begin
                // Youngest producer first.
                if (!is_reg)
                begin
                        o_value = i_operand.value;
                end
                else if (hit_alu_nxt)
                begin
                        o_value = i_fwd.alu_value_nxt;
                end
                else if (hit_alu_ff)
                begin
                        o_value = i_fwd.alu_value_ff;
                end
                else if (hit_mem)
                begin
                        o_value = i_fwd.mem_value;
                end
                else
                begin
                        o_value = i_rd_data;
                end

                // Load data straight off the memory bus wins.
                if (hit_load)
                begin
                        o_value = i_fwd.mem_load_data;
                end
        end

endmodule

/* hdl/pipe_pkg.sv */
package pipe_pkg;

        // One instruction as handed over by decode.
        typedef struct packed
        {
                isa_pkg::cond_t                 cond;
                logic [isa_pkg::IDX_W-1:0]      dest_index;
                isa_pkg::alu_op_t               alu_op;
                isa_pkg::shift_op_t             shift_op;
                isa_pkg::operand_t              alu_source;
                isa_pkg::operand_t              shift_source;
                isa_pkg::operand_t              shift_length;
                logic [isa_pkg::IDX_W-1:0]      mem_srcdest_index;
                logic                           mem_load;
                logic                           mem_store;
                logic [31:0]                    pc_plus_8;
        } decoded_t;

        // Feedback from the shifter, ALU and memory stages.
        typedef struct packed
        {
                // Destination held in the shifter flops.
                logic [isa_pkg::IDX_W-1:0]      shifter_dest_index;

                // ALU result, both before and after its output flops.
                logic                           alu_dav_nxt;
                logic [31:0]                    alu_value_nxt;
                logic [isa_pkg::IDX_W-1:0]      alu_dest_index_ff;
                logic                           alu_dav_ff;
                logic [31:0]                    alu_value_ff;

                // Memory stage result.
                logic [isa_pkg::IDX_W-1:0]      mem_dest_index;
                logic                           mem_dav;
                logic [31:0]                    mem_value;

                // Load tracking per stage.
                logic [isa_pkg::IDX_W-1:0]      shifter_mem_srcdest_index;
                logic                           shifter_mem_load;
                logic [isa_pkg::IDX_W-1:0]      alu_mem_srcdest_index;
                logic                           alu_mem_load;
                logic [isa_pkg::IDX_W-1:0]      memory_mem_srcdest_index;
                logic                           memory_mem_load;

                // Data bus of the memory stage, used to accelerate loads.
                logic [31:0]                    mem_load_data;
        } forward_t;

        // Register file read indices, one per read port.
        typedef struct packed
        {
                logic [isa_pkg::IDX_W-1:0]      alu_source;
                logic [isa_pkg::IDX_W-1:0]      shift_source;
                logic [isa_pkg::IDX_W-1:0]      shift_length;
                logic [isa_pkg::IDX_W-1:0]      mem_srcdest;
        } reg_index_t;

        // Register values, read port order as in reg_index_t.
        typedef struct packed
        {
                logic [31:0]                    alu_source;
                logic [31:0]                    shift_source;
                logic [31:0]                    shift_length;
                logic [31:0]                    mem_srcdest;
        } reg_data_t;

        // Instruction leaving the issue stage towards the shifter.
        typedef struct packed
        {
                decoded_t                       instr;
                reg_data_t                      values;
                logic                           shifter_disable;
        } issued_t;

endpackage

/* hdl/isa_pkg.sv */
package isa_pkg;

        // Physical register file size, including banked copies.
        localparam int PHY_REGS = 46;
        localparam int IDX_W    = $clog2(PHY_REGS);

        // ARM condition field. NV marks an empty slot in the pipeline.
        typedef enum logic [3:0]
        {
                EQ, NE, CS, CC,
                MI, PL, VS, VC,
                HI, LS, GE, LT,
                GT, LE, AL, NV
        } cond_t;

        // The four ARM shifts plus an internal rotate for immediates.
        typedef enum logic [2:0]
        {
                LSL  = 3'd0,
                LSR  = 3'd1,
                ASR  = 3'd2,
                ROR  = 3'd3,
                RORI = 3'd4
        } shift_op_t;

        // Internal ALU operation code, more than the 16 ARM opcodes.
        typedef logic [4:0] alu_op_t;

        // Tagged operand.
        // For a register operand the index sits in the low IDX_W bits of value.
        typedef struct packed
        {
                logic        immed;
                logic [31:0] value;
        } operand_t;

        // Tag value for an immediate operand.
        localparam logic IMMED_EN = 1'b1;

endpackage
